// File: src/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// datapath and bus address width
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// width of every class counter and the cycle counter
`define PERF_W 32

`endif

// File: src/rv_decode_pkg.sv
package rv_decode_pkg;

    // major opcode, instr[6:2]
    typedef enum logic [4:0] {
        OPC_LOAD   = 5'b00000,
        OPC_OP_IMM = 5'b00100,
        OPC_AUIPC  = 5'b00101,
        OPC_STORE  = 5'b01000,
        OPC_OP     = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011,
        OPC_SYSTEM = 5'b11100
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    typedef enum logic [2:0] {
        MEM_BYTE  = 3'd0,
        MEM_HALF  = 3'd1,
        MEM_WORD  = 3'd2,
        MEM_UBYTE = 3'd3,
        MEM_UHALF = 3'd4
    } mem_len_t;

    // also the perf_sel encoding
    typedef enum logic [2:0] {
        CLS_ALU_REG = 3'd0,
        CLS_ALU_IMM = 3'd1,
        CLS_JUMP    = 3'd2,
        CLS_LOAD    = 3'd3,
        CLS_BRANCH  = 3'd4,
        CLS_STORE   = 3'd5,
        CLS_SYSTEM  = 3'd6,
        CLS_ILLEGAL = 3'd7
    } inst_class_t;

    typedef enum logic [1:0] {
        FETCH_REQUEST  = 2'd0,
        FETCH_WAIT_ACK = 2'd1,
        FETCH_HOLD     = 2'd2
    } fetch_state_t;

    typedef enum logic {
        DEC_IDLE = 1'b0,
        DEC_HOLD = 1'b1
    } decode_state_t;

endpackage

// File: src/fetch_decode_if.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

// fetch to decode handoff, transfer on valid && ready
interface fetch_decode_if;
    logic             valid;
    logic             ready;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] pc;

    modport fetch (
        output valid,
        output instr,
        output pc,
        input  ready
    );

    modport decode (
        input  valid,
        input  instr,
        input  pc,
        output ready
    );
endinterface

// File: src/instr_fetch.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module instr_fetch import rv_decode_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output logic [`XLEN-1:0] wb_adr,
    input  logic [`XLEN-1:0] wb_dat_i,
    input  logic             wb_ack,
    input  logic             halt,
    fetch_decode_if.fetch    fd
);

    fetch_state_t     state;
    logic [`XLEN-1:0] pc;        // address of the next read
    logic [`XLEN-1:0] instr_q;
    logic [`XLEN-1:0] instr_pc;
    logic             handoff;

    assign handoff = fd.valid && fd.ready;

    // one classic read at a time, cyc and stb move together
    assign wb_cyc = (state == FETCH_WAIT_ACK);
    assign wb_stb = (state == FETCH_WAIT_ACK);
    assign wb_we  = 1'b0;
    assign wb_adr = pc;

    assign fd.valid = (state == FETCH_HOLD);
    assign fd.instr = instr_q;
    assign fd.pc    = instr_pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH_REQUEST;
            pc    <= `RESET_PC;
        end else begin
            case (state)
                FETCH_REQUEST: begin
                    if (!halt)
                        state <= FETCH_WAIT_ACK;
                end
                FETCH_WAIT_ACK: begin
                    if (wb_ack) begin
                        state <= FETCH_HOLD;
                        pc    <= pc + `XLEN'(4);
                    end
                end
                FETCH_HOLD: begin
                    // bus stays idle at least one cycle before the next read
                    if (handoff && !halt)
                        state <= FETCH_REQUEST;
                end
                default: state <= FETCH_REQUEST;
            endcase
        end
    end

    // word and its pc, held until decode takes them
    always_ff @(posedge clk) begin
        if (state == FETCH_WAIT_ACK && wb_ack) begin
            instr_q  <= wb_dat_i;
            instr_pc <= pc;
        end
    end

endmodule

// File: src/instr_decode.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module instr_decode import rv_decode_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    fetch_decode_if.decode   fd,
    input  logic             ex_ready,
    output logic             dec_valid,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output logic [4:0]       rd,
    output logic [`XLEN-1:0] imm,
    output logic [2:0]       func3,
    output logic [6:0]       func7,
    output alu_op_t          alu_op,
    output mem_len_t         mem_len,
    output logic             reg_write,
    output logic             mem_write,
    output logic             mem_read,
    output inst_class_t      inst_class,
    output logic             illegal,
    output logic             halt,
    output logic             retire,
    output inst_class_t      retire_class,
    output logic             accept_pulse
);

    localparam logic [`XLEN-1:0] EBREAK_WORD = 32'h0010_0073;

    decode_state_t    state;
    logic             ready_q;
    logic [`XLEN-1:0] instr_q;

    opcode_t          opc;
    logic [2:0]       f3;
    logic [6:0]       f7;
    logic [`XLEN-1:0] imm_i, imm_u, imm_s, imm_b, imm_j;
    logic [`XLEN-1:0] d_imm;
    alu_op_t          d_alu;
    mem_len_t         d_len;
    logic             d_rw, d_mw, d_mr, d_illegal;
    inst_class_t      d_class;

    // alt picks sub / sra
    function automatic alu_op_t alu_from_f3(input logic [2:0] f, input logic alt);
        case (f)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign fd.ready     = ready_q;
    assign accept_pulse = fd.valid && ready_q;
    assign retire       = dec_valid && ex_ready;
    assign retire_class = inst_class;

    assign opc = opcode_t'(instr_q[6:2]);
    assign f3  = instr_q[14:12];
    assign f7  = instr_q[31:25];

    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_u = {instr_q[31:12], 12'b0};
    assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_b = {{20{instr_q[31]}}, instr_q[7], instr_q[30:25], instr_q[11:8], 1'b0};
    assign imm_j = {{12{instr_q[31]}}, instr_q[19:12], instr_q[20], instr_q[30:21], 1'b0};

    always_comb begin
        d_imm     = '0;     // r-type keeps zero
        d_alu     = ALU_ADD;
        d_len     = MEM_WORD;
        d_rw      = 1'b0;
        d_mw      = 1'b0;
        d_mr      = 1'b0;
        d_class   = CLS_ILLEGAL;
        d_illegal = 1'b0;
        case (opc)
            OPC_LUI, OPC_AUIPC: begin
                d_imm   = imm_u;
                d_rw    = 1'b1;
                d_class = CLS_ALU_IMM;
            end
            OPC_JAL: begin
                d_imm   = imm_j;
                d_rw    = 1'b1;
                d_class = CLS_JUMP;
            end
            OPC_JALR: begin
                d_imm     = imm_i;
                d_rw      = 1'b1;
                d_class   = CLS_JUMP;
                d_illegal = (f3 != 3'b000);
            end
            OPC_BRANCH: begin
                d_imm   = imm_b;
                d_class = CLS_BRANCH;
                case (f3)
                    3'b000, 3'b001: d_alu = ALU_SUB;     // beq bne
                    3'b100, 3'b101: d_alu = ALU_SLT;     // blt bge
                    3'b110, 3'b111: d_alu = ALU_SLTU;
                    default:        d_illegal = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                d_imm   = imm_i;
                d_rw    = 1'b1;
                d_mr    = 1'b1;
                d_class = CLS_LOAD;
                case (f3)
                    3'b000:  d_len = MEM_BYTE;
                    3'b001:  d_len = MEM_HALF;
                    3'b010:  d_len = MEM_WORD;
                    3'b100:  d_len = MEM_UBYTE;
                    3'b101:  d_len = MEM_UHALF;
                    default: d_illegal = 1'b1;
                endcase
            end
            OPC_STORE: begin
                d_imm   = imm_s;
                d_mw    = 1'b1;
                d_class = CLS_STORE;
                case (f3)
                    3'b000:  d_len = MEM_BYTE;
                    3'b001:  d_len = MEM_HALF;
                    3'b010:  d_len = MEM_WORD;
                    default: d_illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                d_imm   = imm_i;
                d_rw    = 1'b1;
                d_class = CLS_ALU_IMM;
                d_alu   = alu_from_f3(f3, (f3 == 3'b101) && f7[5]); // srai only
            end
            OPC_OP: begin
                d_rw    = 1'b1;
                d_class = CLS_ALU_REG;
                d_alu   = alu_from_f3(f3, f7[5]);
            end
            OPC_SYSTEM: begin
                d_class   = CLS_SYSTEM;
                d_illegal = (f3 != 3'b000);  // no csr support
            end
            default: d_illegal = 1'b1;
        endcase
        if (instr_q[1:0] != 2'b11)
            d_illegal = 1'b1;   // compressed encodings
        if (d_illegal) begin
            d_rw    = 1'b0;
            d_mw    = 1'b0;
            d_mr    = 1'b0;
            d_class = CLS_ILLEGAL;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= DEC_IDLE;
            ready_q   <= 1'b1;
            dec_valid <= 1'b0;
            halt      <= 1'b0;
        end else begin
            case (state)
                DEC_IDLE: begin
                    if (accept_pulse) begin
                        state   <= DEC_HOLD;
                        ready_q <= 1'b0;
                        // raised on entry so fetch never reads past ebreak
                        if (fd.instr == EBREAK_WORD)
                            halt <= 1'b1;
                    end
                end
                DEC_HOLD: begin
                    if (!dec_valid) begin
                        dec_valid <= 1'b1;
                    end else if (ex_ready) begin
                        dec_valid <= 1'b0;
                        ready_q   <= !halt;
                        state     <= DEC_IDLE;
                    end
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept_pulse)
            instr_q <= fd.instr;
    end

    // bundle loads once per instruction, then holds until delivered
    always_ff @(posedge clk) begin
        if (state == DEC_HOLD && !dec_valid) begin
            rs1        <= instr_q[19:15];
            rs2        <= instr_q[24:20];
            rd         <= instr_q[11:7];
            func3      <= f3;
            func7      <= f7;
            imm        <= d_imm;
            alu_op     <= d_alu;
            mem_len    <= d_len;
            reg_write  <= d_rw;
            mem_write  <= d_mw;
            mem_read   <= d_mr;
            inst_class <= d_class;
            illegal    <= d_illegal;
        end
    end

endmodule

// File: src/inst_class_counter.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module inst_class_counter import rv_decode_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              retire,
    input  inst_class_t       retire_class,
    input  logic              accept_pulse,
    input  inst_class_t       perf_sel,
    output logic [`PERF_W-1:0] perf_count,
    output logic [`PERF_W-1:0] start_cycle
);

    logic [`PERF_W-1:0] counts [8];  // indexed by class code
    logic [`PERF_W-1:0] cycle_cnt;

    assign perf_count = counts[perf_sel];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 8; i++)
                counts[i] <= '0;
        end else if (retire) begin
            counts[retire_class] <= counts[retire_class] + 1'b1;
        end
    end

    // free running, wraps
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            cycle_cnt <= '0;
        else
            cycle_cnt <= cycle_cnt + 1'b1;
    end

    // stamp of the most recent decode entry
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            start_cycle <= '0;
        else if (accept_pulse)
            start_cycle <= cycle_cnt;
    end

endmodule

// File: src/decode_core_top.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module decode_core_top import rv_decode_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output logic [`XLEN-1:0]   wb_adr,
    input  logic [`XLEN-1:0]   wb_dat_i,
    input  logic               wb_ack,
    input  logic               ex_ready,
    input  inst_class_t        perf_sel,
    output logic               dec_valid,
    output logic [4:0]         rs1,
    output logic [4:0]         rs2,
    output logic [4:0]         rd,
    output logic [`XLEN-1:0]   imm,
    output logic [2:0]         func3,
    output logic [6:0]         func7,
    output alu_op_t            alu_op,
    output mem_len_t           mem_len,
    output logic               reg_write,
    output logic               mem_write,
    output logic               mem_read,
    output inst_class_t        inst_class,
    output logic               illegal,
    output logic               halt,
    output logic [`PERF_W-1:0] perf_count,
    output logic [`PERF_W-1:0] start_cycle
);

    logic        retire;
    logic        accept_pulse;
    inst_class_t retire_class;

    fetch_decode_if fd_link ();

    instr_fetch instr_fetch_i (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack),
        .halt     (halt),
        .fd       (fd_link.fetch)
    );

    instr_decode instr_decode_i (
        .clk          (clk),
        .reset        (reset),
        .fd           (fd_link.decode),
        .ex_ready     (ex_ready),
        .dec_valid    (dec_valid),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .imm          (imm),
        .func3        (func3),
        .func7        (func7),
        .alu_op       (alu_op),
        .mem_len      (mem_len),
        .reg_write    (reg_write),
        .mem_write    (mem_write),
        .mem_read     (mem_read),
        .inst_class   (inst_class),
        .illegal      (illegal),
        .halt         (halt),
        .retire       (retire),
        .retire_class (retire_class),
        .accept_pulse (accept_pulse)
    );

    inst_class_counter inst_class_counter_i (
        .clk          (clk),
        .reset        (reset),
        .retire       (retire),
        .retire_class (retire_class),
        .accept_pulse (accept_pulse),
        .perf_sel     (perf_sel),
        .perf_count   (perf_count),
        .start_cycle  (start_cycle)
    );

endmodule

// File: tests/decode_core_props.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module decode_core_props import rv_decode_pkg::*; (
    input logic             clk,
    input logic             reset,
    input logic             wb_stb,
    input logic             wb_we,
    input logic             wb_ack,
    input logic [`XLEN-1:0] wb_adr,
    input logic             ex_ready,
    input logic             dec_valid,
    input logic             halt,
    input logic [4:0]       rs1,
    input logic [4:0]       rs2,
    input logic [4:0]       rd,
    input logic [`XLEN-1:0] imm,
    input logic [2:0]       func3,
    input logic [6:0]       func7,
    input alu_op_t          alu_op,
    input mem_len_t         mem_len,
    input logic             reg_write,
    input logic             mem_write,
    input logic             mem_read,
    input inst_class_t      inst_class,
    input logic             illegal
);

    int unsigned fail_cnt = 0;  // failed assertions so far

    // stalled bundle stays put
    a_bundle_hold: assert property (@(posedge clk) disable iff (reset)
        dec_valid && !ex_ready |=> dec_valid && $stable({rs1, rs2, rd, imm, func3, func7,
            alu_op, mem_len, reg_write, mem_write, mem_read, inst_class, illegal}))
    else begin
        fail_cnt++;
        $error("decode bundle changed while ex_ready was low");
    end

    a_no_stb_on_halt: assert property (@(posedge clk) disable iff (reset) halt |-> !wb_stb)
    else begin
        fail_cnt++;
        $error("wishbone strobe raised after halt");
    end

    a_read_only: assert property (@(posedge clk) disable iff (reset) !wb_we)
    else begin
        fail_cnt++;
        $error("wishbone write enable raised");
    end

    // classic cycle, address held until ack
    a_adr_stable: assert property (@(posedge clk) disable iff (reset)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
    else begin
        fail_cnt++;
        $error("wishbone strobe or address moved before ack");
    end

endmodule

bind decode_core_top decode_core_props decode_core_props_i (.*);

// File: tests/decode_core_tb.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module decode_core_tb import rv_decode_pkg::*; ();

    localparam int N_ENTRIES   = 23;
    localparam int WATCHDOG_NS = 40 * N_ENTRIES * 20;

    logic               clk = 1'b0;
    logic               reset;
    logic               wb_cyc, wb_stb, wb_we, wb_ack;
    logic [`XLEN-1:0]   wb_adr, wb_dat_i;
    logic               ex_ready;
    inst_class_t        perf_sel;
    logic               dec_valid, reg_write, mem_write, mem_read, illegal, halt;
    logic [4:0]         rs1, rs2, rd;
    logic [`XLEN-1:0]   imm;
    logic [2:0]         func3;
    logic [6:0]         func7;
    alu_op_t            alu_op;
    mem_len_t           mem_len;
    inst_class_t        inst_class;
    logic [`PERF_W-1:0] perf_count, start_cycle;

    logic [63:0] tdata [0:3*N_ENTRIES-1];  // word, imm, packed fields
    int unsigned tally [8];
    int unsigned errors  = 0;
    int unsigned del_cnt = 0;
    int unsigned req_cnt = 0;
    int unsigned wait_left;
    int unsigned cycle_no = 0;  // edges since reset release
    logic             stalled = 1'b0;
    logic             valid_q = 1'b0;
    logic [`PERF_W-1:0] exp_start;
    logic [`XLEN-1:0] held_imm;
    alu_op_t          held_alu;
    mem_len_t         held_len;
    inst_class_t      held_class;

    always #10 clk = ~clk;

    decode_core_top decode_core_top_i (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .ex_ready(ex_ready), .perf_sel(perf_sel), .dec_valid(dec_valid),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .func3(func3), .func7(func7),
        .alu_op(alu_op), .mem_len(mem_len), .reg_write(reg_write),
        .mem_write(mem_write), .mem_read(mem_read), .inst_class(inst_class),
        .illegal(illegal), .halt(halt), .perf_count(perf_count), .start_cycle(start_cycle)
    );

    task automatic check_word(input string name, input logic [`XLEN-1:0] got, exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_alu_op(input string name, input alu_op_t got, exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_mem_len(input string name, input mem_len_t got, exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_class(input string name, input inst_class_t got, exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // field layout as documented at the top of the data file
    task automatic check_bundle(input int unsigned idx);
        logic [63:0] f;
        f = tdata[3 * idx + 2];
        check_word("imm", imm, tdata[3 * idx + 1][31:0]);
        check_word("rs1", rs1, f[55:48]);
        check_word("rs2", rs2, f[47:40]);
        check_word("rd", rd, f[39:32]);
        check_word("func3", func3, f[31:28]);
        check_word("func7", func7, f[27:20]);
        check_alu_op("alu_op", alu_op, alu_op_t'(f[19:16]));
        check_mem_len("mem_len", mem_len, mem_len_t'(f[14:12]));
        check_word("reg_write", reg_write, f[10]);
        check_word("mem_write", mem_write, f[9]);
        check_word("mem_read", mem_read, f[8]);
        check_class("inst_class", inst_class, inst_class_t'(f[6:4]));
        check_word("illegal", illegal, f[0]);
        if (illegal)
            check_word("write flags", {reg_write, mem_write, mem_read}, '0);
    endtask

    // wishbone slave, 0 to 3 wait cycles
    always @(posedge clk) begin
        wb_ack <= 1'b0;
        if (wb_cyc && wb_stb && !wb_ack) begin
            if (wait_left == 0) begin
                check_word("wb_adr", wb_adr, req_cnt * 4);
                if (wb_adr[31:2] >= N_ENTRIES) begin
                    errors++;
                    $display("fetch read past the end of the program at %0t", $time);
                end else begin
                    wb_dat_i <= tdata[3 * wb_adr[31:2]][31:0];
                end
                wb_ack <= 1'b1;
                req_cnt++;
                wait_left = $urandom % 4;
            end else begin
                wait_left--;
            end
        end
    end

    always @(posedge clk)
        ex_ready <= ($urandom % 3) != 0;    // low about a third of the time

    always @(posedge clk) begin
        if (!reset) begin
            if (stalled) begin
                check_word("imm held", imm, held_imm);
                check_alu_op("alu_op held", alu_op, held_alu);
                check_mem_len("mem_len held", mem_len, held_len);
                check_class("inst_class held", inst_class, held_class);
            end
            if (dec_valid && !valid_q)
                exp_start = cycle_no - 2;   // taken two edges before dec_valid is seen
            if (dec_valid && ex_ready) begin
                if (del_cnt >= N_ENTRIES) begin
                    errors++;
                    $display("extra delivery after the last program entry at %0t", $time);
                end else begin
                    check_bundle(del_cnt);
                    check_word("start_cycle", start_cycle, exp_start);
                end
                del_cnt++;
            end
            stalled    = dec_valid && !ex_ready;
            valid_q    = dec_valid;
            held_imm   = imm;
            held_alu   = alu_op;
            held_len   = mem_len;
            held_class = inst_class;
            cycle_no++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d of %0d deliveries", del_cnt, N_ENTRIES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int unsigned prop_fails;
        void'($urandom(32'he50c));
        reset    = 1'b1;
        wb_ack   = 1'b0;
        wb_dat_i = '0;
        ex_ready = 1'b0;
        perf_sel = CLS_ALU_REG;
        $readmemh("tests/decode_testdata.hex", tdata);
        wait_left = $urandom % 4;
        for (int c = 0; c < 8; c++)
            tally[c] = 0;
        for (int i = 0; i < N_ENTRIES; i++)
            tally[tdata[3 * i + 2][6:4]]++;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        wait (del_cnt == N_ENTRIES);
        // ebreak delivered, front end must stay parked
        repeat (20) begin
            @(posedge clk);
            check_word("halt", halt, 1'b1);
            check_word("wb_cyc", wb_cyc, 1'b0);
        end
        for (int s = 0; s < 8; s++) begin
            @(posedge clk);
            perf_sel <= inst_class_t'(s);
            @(posedge clk);
            check_word("perf_count", perf_count, tally[s]);
        end
        check_word("bus requests", req_cnt, N_ENTRIES);

        prop_fails = decode_core_top_i.decode_core_props_i.fail_cnt;
        $display("errors: %0d testbench checks, %0d assertions", errors, prop_fails);
        if (errors == 0 && prop_fails == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: build.f
+incdir+src
src/rv_decode_pkg.sv
src/fetch_decode_if.sv
src/instr_fetch.sv
src/instr_decode.sv
src/inst_class_counter.sv
src/decode_core_top.sv
tests/decode_core_props.sv
tests/decode_core_tb.sv

// File: tests/decode_testdata.hex
// instruction word, expected imm, packed fields in hex digits from the msb:
// rs1(2) rs2(2) rd(2) func3(1) func7(2) alu_op(1) mem_len(1) rw/mw/mr(1) class(1) illegal(1)
00500093 00000005 00050100002410  // addi x1, x0, 5
FFF00113 FFFFFFFF 001F0207F02410  // addi x2, x0, -1
002081B3 00000000 01020300002400  // add x3, x1, x2
40118233 00000000 03010402012400  // sub x4, x3, x1
402252B3 00000000 04020552072400  // sra x5, x4, x2
0020B333 00000000 01020630092400  // sltu x6, x1, x2
0FF0C393 000000FF 011F0740742410  // xori x7, x1, 0xff
4033D413 00000403 07030852072410  // srai x8, x7, 3
00409493 00000004 01040910052410  // slli x9, x1, 4
12345537 12345000 08030A50902410  // lui x10, 0x12345
00001597 00001000 00000B10002410  // auipc x11, 0x1
008000EF 00000008 00080100002420  // jal x1, 8
00008067 00000000 01000000002420  // jalr x0, 0(x1)
FE208EE3 FFFFFFFC 01021D07F12040  // beq x1, x2, -4
0041E863 00000010 03041060092040  // bltu x3, x4, 16
0002D463 00000008 05000850082040  // bge x5, x0, 8
00412603 00000004 02040C20002530  // lw x12, 4(x2)
FFF14683 FFFFFFFF 021F0D47F03530  // lbu x13, -1(x2)
00309323 00000006 01030610001250  // sh x3, 6(x1)
FE410C23 FFFFFFF8 02041807F00250  // sb x4, -8(x2)
0000000B 00000000 00000000002071  // unknown opcode
00003083 00000000 00000130002071  // load with func3 3
00100073 00000000 00010000002060  // ebreak
